/* rtl/bypassLsu.sv */
`include "lsuDefines.svh"

module bypassLsu import uopPkg::*, memcPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  branchProv   branch,
    input  logic        uopLdEn,
    input  ldUop        uopLd,
    input  logic        uopStEn,
    input  stUop        uopSt,
    input  logic        ldStall,
    input  memcRes      memcIn,
    output logic        ldStallOut,
    output logic        stStallOut,
    output ldUop        uopLdOut,
    output logic [31:0] ldData,
    output memcReq      memcOut
);

    typedef enum logic [2:0] {IDLE, REQ_LD, REQ_ST, WAIT_LD, WAIT_ST, DONE_LD} lsuState;

    lsuState state;
    ldUop    activeLd;
    logic    takeSt;
    logic    takeLd;
    logic    squashHeld;
    logic    keepLd;

    // sequence numbers wrap, so age is judged by the sign of the difference
    function automatic logic squashes(ldUop ld, branchProv br);
        logic signed [`LSU_SQN_W-1:0] age;
        age = ld.sqN - br.sqN;
        return br.taken && !ld.external && (age > 0);
    endfunction

    function automatic logic [1:0] lowestLane(logic [3:0] mask);
        logic [1:0] lane;
        lane = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (mask[i]) begin
                lane = 2'(i);
            end
        end
        return lane;
    endfunction

    function automatic memCmd storeCmd(logic [3:0] mask);
        case (mask)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: return MEMC_WRITE_BYTE;
            4'b0011, 4'b1100: return MEMC_WRITE_HALF;
            default: return MEMC_WRITE_WORD;
        endcase
    endfunction

    function automatic memCmd loadCmd(logic [1:0] size);
        case (size)
            2'd0: return MEMC_READ_BYTE;
            2'd1: return MEMC_READ_HALF;
            default: return MEMC_READ_WORD;
        endcase
    endfunction

    always_comb begin
        stStallOut = (state != IDLE);
        // a waiting store always goes ahead of a load
        ldStallOut = stStallOut || uopSt.valid;
        takeSt = uopSt.valid && uopStEn && !stStallOut;
        takeLd = uopLd.valid && uopLdEn && !ldStallOut && !squashes(uopLd, branch);
        squashHeld = activeLd.valid && squashes(activeLd, branch);
        keepLd = activeLd.valid && !squashHeld;
        uopLdOut = activeLd;
        uopLdOut.valid = (state == DONE_LD) && activeLd.valid;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            activeLd <= '0;
            memcOut <= memcReq'{cmd: MEMC_NONE, default: '0};
        end else begin
            // a squashed load keeps its transaction but loses its result
            if (squashHeld) begin
                activeLd.valid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (takeSt) begin
                        memcOut.cmd <= storeCmd(uopSt.wmask);
                        memcOut.writeAddr <= {uopSt.addr[`LSU_ADDR_W-1:2],
                                              lowestLane(uopSt.wmask)};
                        memcOut.data <= uopSt.data;
                        state <= REQ_ST;
                    end else if (takeLd) begin
                        memcOut.cmd <= loadCmd(uopLd.size);
                        memcOut.readAddr <= uopLd.addr;
                        activeLd <= uopLd;
                        state <= REQ_LD;
                    end
                end
                REQ_LD, REQ_ST: begin
                    if (!memcIn.stall) begin
                        memcOut.cmd <= MEMC_NONE;
                        state <= (state == REQ_LD) ? WAIT_LD : WAIT_ST;
                    end
                end
                WAIT_LD: begin
                    if (memcIn.ldValid) begin
                        state <= keepLd ? DONE_LD : IDLE;
                    end
                end
                WAIT_ST: begin
                    if (memcIn.stValid) begin
                        state <= IDLE;
                    end
                end
                DONE_LD: begin
                    if (!ldStall || !activeLd.valid) begin
                        state <= IDLE;
                        activeLd.valid <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // narrow results are repeated across the whole word
    always_ff @(posedge clk) begin
        if (state == WAIT_LD && memcIn.ldValid) begin
            case (activeLd.size)
                2'd0: ldData <= {4{memcIn.ldData[7:0]}};
                2'd1: ldData <= {2{memcIn.ldData[15:0]}};
                default: ldData <= memcIn.ldData;
            endcase
        end
    end

endmodule

/* rtl/debugAccess.sv */
`include "lsuDefines.svh"

module debugAccess import memcPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dbgReq,
    input  logic                   dbgWrite,
    input  logic [`LSU_ADDR_W-1:0] dbgAddr,
    input  logic [31:0]            dbgWdata,
    input  memcRes                 memcIn,
    output logic                   dbgBusy,
    output logic                   dbgDone,
    output logic [31:0]            dbgRdata,
    output memcReq                 memcOut
);

    logic waiting;
    logic respSeen;

    always_comb begin
        waiting = dbgBusy && (memcOut.cmd == MEMC_NONE);
        respSeen = waiting && (memcIn.ldValid || memcIn.stValid);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dbgBusy <= 1'b0;
            dbgDone <= 1'b0;
            memcOut <= memcReq'{cmd: MEMC_NONE, default: '0};
        end else begin
            dbgDone <= respSeen;
            if (!dbgBusy) begin
                // strobes during a busy access are dropped
                if (dbgReq) begin
                    dbgBusy <= 1'b1;
                    memcOut.cmd <= dbgWrite ? MEMC_WRITE_WORD : MEMC_READ_WORD;
                    memcOut.readAddr <= {dbgAddr[`LSU_ADDR_W-1:2], 2'b00};
                    memcOut.writeAddr <= {dbgAddr[`LSU_ADDR_W-1:2], 2'b00};
                    memcOut.data <= dbgWdata;
                end
            end else if (memcOut.cmd != MEMC_NONE) begin
                if (!memcIn.stall) begin
                    memcOut.cmd <= MEMC_NONE;
                end
            end else if (respSeen) begin
                dbgBusy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (respSeen && memcIn.ldValid) begin
            dbgRdata <= memcIn.ldData;
        end
    end

endmodule

/* rtl/lsuDefines.svh */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

`define LSU_ADDR_W 32
`define LSU_SQN_W 7

// on-chip array size in 32-bit words
`define LSU_MEM_WORDS 256

// cycles from command acceptance to the response pulse
`define LSU_MEMC_LAT 3

`endif

/* rtl/lsuTop.sv */
`include "lsuDefines.svh"

module lsuTop import uopPkg::*, memcPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  branchProv              branch,
    input  logic                   uopLdEn,
    input  ldUop                   uopLd,
    output logic                   ldStallOut,
    input  logic                   uopStEn,
    input  stUop                   uopSt,
    output logic                   stStallOut,
    input  logic                   ldStall,
    output ldUop                   ldUopOut,
    output logic [31:0]            ldData,
    input  logic                   dbgReq,
    input  logic                   dbgWrite,
    input  logic [`LSU_ADDR_W-1:0] dbgAddr,
    input  logic [31:0]            dbgWdata,
    output logic                   dbgBusy,
    output logic                   dbgDone,
    output logic [31:0]            dbgRdata
);

    memcReq lsuMemcReq;
    memcRes lsuMemcRes;
    memcReq dbgMemcReq;
    memcRes dbgMemcRes;
    memcReq ctrlReq;
    memcRes ctrlRes;

    bypassLsu lsu (
        .clk, .rst, .branch, .uopLdEn, .uopLd, .uopStEn, .uopSt, .ldStall,
        .memcIn(lsuMemcRes), .ldStallOut, .stStallOut, .uopLdOut(ldUopOut),
        .ldData, .memcOut(lsuMemcReq)
    );

    debugAccess dbg (
        .clk, .rst, .dbgReq, .dbgWrite, .dbgAddr, .dbgWdata,
        .memcIn(dbgMemcRes), .dbgBusy, .dbgDone, .dbgRdata, .memcOut(dbgMemcReq)
    );

    memArbiter arb (
        .clk, .rst, .lsuReq(lsuMemcReq), .dbgReq(dbgMemcReq), .memcIn(ctrlRes),
        .lsuRes(lsuMemcRes), .dbgRes(dbgMemcRes), .memcOut(ctrlReq)
    );

    sramMemController memc (
        .clk, .rst, .req(ctrlReq), .res(ctrlRes)
    );

endmodule

/* rtl/memArbiter.sv */
module memArbiter import memcPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  memcReq lsuReq,
    input  memcReq dbgReq,
    input  memcRes memcIn,
    output memcRes lsuRes,
    output memcRes dbgRes,
    output memcReq memcOut
);

    typedef enum logic [1:0] {OWN_NONE, OWN_LSU, OWN_DBG} ownerSel;

    ownerSel owner;
    logic    selLsu;
    logic    selDbg;
    logic    accepted;
    logic    respDone;

    always_comb begin
        selLsu = 1'b0;
        selDbg = 1'b0;
        case (owner)
            OWN_LSU: selLsu = 1'b1;
            OWN_DBG: selDbg = 1'b1;
            default: begin
                // the load/store unit wins a tie
                if (lsuReq.cmd != MEMC_NONE) begin
                    selLsu = 1'b1;
                end else if (dbgReq.cmd != MEMC_NONE) begin
                    selDbg = 1'b1;
                end
            end
        endcase

        if (selLsu) begin
            memcOut = lsuReq;
        end else if (selDbg) begin
            memcOut = dbgReq;
        end else begin
            memcOut = memcReq'{cmd: MEMC_NONE, default: '0};
        end

        lsuRes = memcIn;
        dbgRes = memcIn;
        if (!selLsu) begin
            lsuRes.stall = 1'b1;
            lsuRes.ldValid = 1'b0;
            lsuRes.stValid = 1'b0;
        end
        if (!selDbg) begin
            dbgRes.stall = 1'b1;
            dbgRes.ldValid = 1'b0;
            dbgRes.stValid = 1'b0;
        end

        accepted = (owner == OWN_NONE) && (memcOut.cmd != MEMC_NONE) && !memcIn.stall;
        respDone = memcIn.ldValid || memcIn.stValid;
    end

    // ownership lasts from acceptance through the response pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner <= OWN_NONE;
        end else if (accepted) begin
            owner <= selLsu ? OWN_LSU : OWN_DBG;
        end else if (owner != OWN_NONE && respDone) begin
            owner <= OWN_NONE;
        end
    end

endmodule

/* rtl/memcPkg.sv */
`include "lsuDefines.svh"

package memcPkg;

    typedef enum logic [2:0] {
        MEMC_NONE,
        MEMC_READ_BYTE,
        MEMC_READ_HALF,
        MEMC_READ_WORD,
        MEMC_WRITE_BYTE,
        MEMC_WRITE_HALF,
        MEMC_WRITE_WORD
    } memCmd;

    typedef struct packed {
        memCmd                  cmd;
        logic [`LSU_ADDR_W-1:0] readAddr;
        // low two bits give the first written byte lane
        logic [`LSU_ADDR_W-1:0] writeAddr;
        logic [31:0]            data;
    } memcReq;

    typedef struct packed {
        logic        stall;
        logic        ldValid;
        logic        stValid;
        // right-aligned read data, meaningful with ldValid
        logic [31:0] ldData;
    } memcRes;

endpackage

/* rtl/sramMemController.sv */
`include "lsuDefines.svh"

module sramMemController import memcPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  memcReq req,
    output memcRes res
);

    localparam int LAT = `LSU_MEMC_LAT;
    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
    localparam int CNT_W = $clog2(LAT + 1);

    logic [31:0]      mem [`LSU_MEM_WORDS];
    logic             busy;
    logic             pendWrite;
    logic [CNT_W-1:0] cnt;
    logic             ldValid;
    logic             stValid;
    logic [31:0]      rdData;
    logic [31:0]      rdWord;
    logic [31:0]      rdAligned;
    logic [3:0]       byteEn;
    logic             accept;
    logic             isWrite;
    logic [IDX_W-1:0] rdIdx;
    logic [IDX_W-1:0] wrIdx;

    always_comb begin
        accept = (req.cmd != MEMC_NONE) && !busy;
        isWrite = req.cmd inside {MEMC_WRITE_BYTE, MEMC_WRITE_HALF, MEMC_WRITE_WORD};
        rdIdx = req.readAddr[IDX_W+1:2];
        wrIdx = req.writeAddr[IDX_W+1:2];
        rdWord = mem[rdIdx];

        case (req.cmd)
            MEMC_READ_BYTE: rdAligned = {24'b0, rdWord[8*req.readAddr[1:0] +: 8]};
            MEMC_READ_HALF: rdAligned = {16'b0, rdWord[16*req.readAddr[1] +: 16]};
            default: rdAligned = rdWord;
        endcase

        case (req.cmd)
            MEMC_WRITE_BYTE: byteEn = 4'b0001 << req.writeAddr[1:0];
            MEMC_WRITE_HALF: byteEn = req.writeAddr[1] ? 4'b1100 : 4'b0011;
            default: byteEn = 4'b1111;
        endcase

        res.stall = busy;
        res.ldValid = ldValid;
        res.stValid = stValid;
        res.ldData = rdData;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            pendWrite <= 1'b0;
            cnt <= '0;
            ldValid <= 1'b0;
            stValid <= 1'b0;
        end else begin
            ldValid <= 1'b0;
            stValid <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                pendWrite <= isWrite;
                cnt <= CNT_W'(LAT - 1);
            end else if (busy) begin
                if (cnt == '0) begin
                    busy <= 1'b0;
                    ldValid <= !pendWrite;
                    stValid <= pendWrite;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    // the access itself happens at acceptance, only the response is delayed
    always_ff @(posedge clk) begin
        if (accept && !isWrite) begin
            rdData <= rdAligned;
        end
        if (accept && isWrite) begin
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b]) begin
                    mem[wrIdx][8*b +: 8] <= req.data[8*b +: 8];
                end
            end
        end
    end

endmodule

/* rtl/uopPkg.sv */
`include "lsuDefines.svh"

package uopPkg;

    typedef struct packed {
        logic                   valid;
        logic [`LSU_ADDR_W-1:0] addr;
        // 0 byte, 1 half, 2 word
        logic [1:0]             size;
        logic [`LSU_SQN_W-1:0]  sqN;
        // device loads cannot be squashed by a branch
        logic                   external;
    } ldUop;

    typedef struct packed {
        logic                   valid;
        logic [`LSU_ADDR_W-1:0] addr;
        // data sits in its byte lanes already
        logic [31:0]            data;
        logic [3:0]             wmask;
        logic [`LSU_SQN_W-1:0]  sqN;
    } stUop;

    typedef struct packed {
        logic                  taken;
        logic [`LSU_SQN_W-1:0] sqN;
    } branchProv;

endpackage

/* run.sh */
#!/bin/sh
# build and run the lsuTb simulation with Verilator
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module lsuTb -o lsuSim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/lsuSim > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1 || grep -q ">>> PASS" sim.log || exit 1
exit 0

/* sim.f */
+incdir+rtl
rtl/uopPkg.sv
rtl/memcPkg.sv
rtl/bypassLsu.sv
rtl/debugAccess.sv
rtl/memArbiter.sv
rtl/sramMemController.sv
rtl/lsuTop.sv
tests/clockGen.sv
tests/lsuAssertions.sv
tests/lsuTb.sv

/* tests/clockGen.sv */
module clockGen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

/* tests/lsuAssertions.sv */
module lsuAssertions import memcPkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       ldStallOut,
    input logic       stStallOut,
    input logic [2:0] lsuState,
    input logic [1:0] owner,
    input memCmd      lsuCmd,
    input memcRes     lsuRes,
    input memcRes     dbgRes
);
    timeunit 1ns;
    timeprecision 100ps;

    // an idle unit that stalls loads must not start one, so a waiting store goes first
    stallOrder: assert property (@(posedge clk) disable iff (rst)
        (ldStallOut && !stStallOut) |=> (lsuState != 3'd1))
        else $error("load accepted while ldStallOut was high");

    // owner encoding is 1 for the load/store unit and 2 for the debug port
    lsuResOwner: assert property (@(posedge clk) disable iff (rst)
        (owner != 2'd1) |-> !(lsuRes.ldValid || lsuRes.stValid))
        else $error("response routed to the load/store unit without ownership");
    dbgResOwner: assert property (@(posedge clk) disable iff (rst)
        (owner != 2'd2) |-> !(dbgRes.ldValid || dbgRes.stValid))
        else $error("response routed to the debug port without ownership");

    // REQ_LD, WAIT_LD and DONE_LD are the load states
    noWriteInLoad: assert property (@(posedge clk) disable iff (rst)
        (lsuState inside {3'd1, 3'd3, 3'd5}) |-> !(lsuCmd inside
        {MEMC_WRITE_BYTE, MEMC_WRITE_HALF, MEMC_WRITE_WORD}))
        else $error("write command issued during a load");

endmodule

bind lsuTop lsuAssertions checks (
    .clk(clk), .rst(rst), .ldStallOut(ldStallOut), .stStallOut(stStallOut),
    .lsuState(lsu.state), .owner(arb.owner), .lsuCmd(lsuMemcReq.cmd),
    .lsuRes(lsuMemcRes), .dbgRes(dbgMemcRes)
);

/* tests/lsuTb.sv */
module lsuTb import uopPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        rst;
    branchProv   branch;
    logic        uopLdEn;
    ldUop        uopLd;
    logic        ldStallOut;
    logic        uopStEn;
    stUop        uopSt;
    logic        stStallOut;
    logic        ldStall;
    ldUop        ldUopOut;
    logic [31:0] ldData;
    logic        dbgReq;
    logic        dbgWrite;
    logic [31:0] dbgAddr;
    logic [31:0] dbgWdata;
    logic        dbgBusy;
    logic        dbgDone;
    logic [31:0] dbgRdata;

    reg [127:0]  opArr [64];
    logic [31:0] addrArr [64];
    logic [31:0] dataArr [64];
    logic [31:0] sizeArr [64];
    logic [31:0] sqnArr [64];
    logic [31:0] brArr [64];
    logic [31:0] expArr [64];
    int          nSteps = 0;
    int          errors = 0;
    int          cycles = 0;
    int          limit = 0;
    integer      seed = 32'ha22f;

    clockGen clkGen (.clk, .rst);

    lsuTop uut (
        .clk, .rst, .branch, .uopLdEn, .uopLd, .ldStallOut, .uopStEn, .uopSt,
        .stStallOut, .ldStall, .ldUopOut, .ldData, .dbgReq, .dbgWrite, .dbgAddr,
        .dbgWdata, .dbgBusy, .dbgDone, .dbgRdata
    );

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic waitCycle;
        @(posedge clk);
        #1;
    endtask

    task automatic compareWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic checkIdleAfterReset;
        if (stStallOut || ldStallOut || ldUopOut.valid || dbgBusy || dbgDone) begin
            errors++;
            $display("reset: a stall, valid, busy or done output is not low after reset");
        end
    endtask

    task automatic debugAccessRun(input logic wr, input logic [31:0] a, input logic [31:0] d);
        dbgReq = 1'b1;
        dbgWrite = wr;
        dbgAddr = a;
        dbgWdata = d;
        waitCycle;
        dbgReq = 1'b0;
        if (!dbgBusy) begin
            errors++;
            $display("debug access: dbgBusy did not rise after the strobe");
        end
        while (!dbgDone) waitCycle;
        if (dbgBusy) begin
            errors++;
            $display("debug access: dbgBusy was still high together with dbgDone");
        end
    endtask

    task automatic presentStore(input logic [31:0] a, input logic [31:0] d, input logic [3:0] m);
        uopSt = '{valid: 1'b1, addr: a, data: d, wmask: m, sqN: 7'd1};
        uopStEn = 1'b1;
    endtask

    task automatic storeRun(input logic [31:0] a, input logic [31:0] d, input logic [3:0] m);
        while (stStallOut) waitCycle;
        presentStore(a, d, m);
        waitCycle;
        uopSt.valid = 1'b0;
        while (stStallOut) waitCycle;
    endtask

    task automatic presentLoad(input logic [31:0] a, input logic [1:0] sz, input logic [6:0] sq,
                               input logic ext);
        uopLd = '{valid: 1'b1, addr: a, size: sz, sqN: sq, external: ext};
        uopLdEn = 1'b1;
    endtask

    task automatic loadRun(input string name, input int i, input logic ext);
        presentLoad(addrArr[i], sizeArr[i][1:0], sqnArr[i][6:0], ext);
        waitCycle;
        uopLd.valid = 1'b0;
        while (!ldUopOut.valid) waitCycle;
        compareWord(name, expArr[i], ldData);
        compareWord({name, " addr"}, addrArr[i], ldUopOut.addr);
        waitCycle;
    endtask

    task automatic squashRun(input int i);
        logic sawValid;
        sawValid = 1'b0;
        branch = '{taken: 1'b1, sqN: brArr[i][6:0]};
        if (dataArr[i] == 0) begin
            // the branch is already taken when the load shows up
            presentLoad(addrArr[i], sizeArr[i][1:0], sqnArr[i][6:0], 1'b0);
            repeat (3) begin
                waitCycle;
                if (stStallOut || ldUopOut.valid) sawValid = 1'b1;
            end
            uopLd.valid = 1'b0;
        end else if (dataArr[i] == 1) begin
            branch.taken = 1'b0;
            presentLoad(addrArr[i], sizeArr[i][1:0], sqnArr[i][6:0], 1'b0);
            waitCycle;
            uopLd.valid = 1'b0;
            branch.taken = 1'b1;
            waitCycle;
            branch.taken = 1'b0;
            while (stStallOut) begin
                if (ldUopOut.valid) sawValid = 1'b1;
                waitCycle;
            end
        end else begin
            loadRun("squashLoad external", i, 1'b1);
        end
        branch.taken = 1'b0;
        if (sawValid) begin
            errors++;
            $display("squashLoad step %0d: a squashed load still produced a result", i);
        end
    endtask

    task automatic heldLoadRun(input int i);
        int          held;
        logic [31:0] snap;
        ldStall = 1'b1;
        presentLoad(addrArr[i], sizeArr[i][1:0], sqnArr[i][6:0], 1'b0);
        waitCycle;
        uopLd.valid = 1'b0;
        while (!ldUopOut.valid) waitCycle;
        compareWord("heldLoad", expArr[i], ldData);
        snap = ldData;
        held = ($unsigned($random(seed)) % 6) + 2;
        presentStore(addrArr[i] + 4, dataArr[i], 4'hf);
        repeat (held) begin
            waitCycle;
            if (!ldUopOut.valid) begin
                errors++;
                $display("heldLoad: the load result was dropped while ldStall was high");
            end
            compareWord("heldLoad steady", snap, ldData);
            if (!stStallOut || !ldStallOut) begin
                errors++;
                $display("heldLoad: the unit stopped stalling while a load was held");
            end
        end
        ldStall = 1'b0;
        waitCycle;
        if (stStallOut) begin
            errors++;
            $display("heldLoad: the held load was not released after ldStall fell");
        end
        if (!ldStallOut) begin
            errors++;
            $display("heldLoad: loads were not stalled behind the waiting store");
        end
        while (!stStallOut) waitCycle;
        uopSt.valid = 1'b0;
        while (stStallOut) waitCycle;
    endtask

    task automatic contendRun(input int i);
        logic loadSeen;
        logic doneSeen;
        loadSeen = 1'b0;
        doneSeen = 1'b0;
        dbgReq = 1'b1;
        dbgWrite = 1'b0;
        dbgAddr = addrArr[i];
        presentLoad(addrArr[i], sizeArr[i][1:0], sqnArr[i][6:0], 1'b0);
        waitCycle;
        dbgReq = 1'b0;
        uopLd.valid = 1'b0;
        while (!doneSeen) begin
            if (ldUopOut.valid && !loadSeen) begin
                loadSeen = 1'b1;
                compareWord("contend load", expArr[i], ldData);
            end
            if (dbgDone) begin
                doneSeen = 1'b1;
                compareWord("contend dbgRead", expArr[i], dbgRdata);
                if (!loadSeen) begin
                    errors++;
                    $display("contend: the debug read finished before the load");
                end
            end
            waitCycle;
        end
    endtask

    initial begin
        int    fd;
        int    code;
        string lineText;
        branch = '0;
        uopLdEn = 1'b0;
        uopLd = '0;
        uopStEn = 1'b0;
        uopSt = '0;
        ldStall = 1'b0;
        dbgReq = 1'b0;
        dbgWrite = 1'b0;
        dbgAddr = '0;
        dbgWdata = '0;

        fd = $fopen("tests/lsu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            $display(">>> FAIL");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(lineText, fd);
                if (code > 1 && lineText[0] != "#") begin
                    code = $sscanf(lineText, "%s %h %h %h %h %h %h", opArr[nSteps],
                                   addrArr[nSteps], dataArr[nSteps], sizeArr[nSteps],
                                   sqnArr[nSteps], brArr[nSteps], expArr[nSteps]);
                    if (code == 7) nSteps++;
                end
            end
            $fclose(fd);
            limit = 40 * nSteps + 100;

            @(negedge rst);
            waitCycle;
            checkIdleAfterReset;
            for (int i = 0; i < nSteps; i++) begin
                case (opArr[i])
                    "dbgWrite": debugAccessRun(1'b1, addrArr[i], dataArr[i]);
                    "dbgRead": begin
                        debugAccessRun(1'b0, addrArr[i], 32'h0);
                        compareWord("dbgRead", expArr[i], dbgRdata);
                    end
                    "store": storeRun(addrArr[i], dataArr[i], sizeArr[i][3:0]);
                    "load": loadRun("load", i, 1'b0);
                    "squashLoad": squashRun(i);
                    "heldLoad": heldLoadRun(i);
                    "contend": contendRun(i);
                    default: begin
                        errors++;
                        $display("unknown operation on stimulus step %0d", i);
                    end
                endcase
                waitCycle;
            end

            $display("steps: %0d  errors: %0d", nSteps, errors);
            if (errors == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

/* tests/lsu_stimulus.txt */
# op addr data size sqN brSqN expected, all hex
# store: size holds wmask; squashLoad: data 0 on issue, 1 in flight, 2 external
dbgWrite 10 11223344 0 0 0 0
dbgRead 10 0 0 0 0 11223344
dbgWrite 20 aabbccdd 0 0 0 0
store 20 00000055 1 1 0 0
store 20 66770000 c 2 0 0
dbgRead 20 0 0 0 0 6677cc55
store 20 00990000 4 3 0 0
dbgRead 20 0 0 0 0 6699cc55
store 24 12345678 f 4 0 0
dbgRead 24 0 0 0 0 12345678
load 11 0 0 8 0 33333333
load 12 0 1 9 0 11221122
load 10 0 2 a 0 11223344
load 13 0 0 b 0 11111111
squashLoad 10 0 2 10 5 0
squashLoad 10 1 2 10 5 0
squashLoad 10 2 2 10 5 11223344
heldLoad 20 cafef00d 1 c 0 cc55cc55
dbgRead 24 0 0 0 0 cafef00d
contend 24 0 2 d 0 cafef00d
